// ==== pipe_defs.svh ====
//------------------------------
// Widths and CSR numbers shared by the control RTL and the testbench
// RV32 only; CSR numbers follow the manager port convention
//------------------------------
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Instruction word and field widths
`define PIPE_XLEN     32
`define PIPE_RADDR_W  5
`define PIPE_CSR_W    12

// Manager CSRs
`define PIPE_CSR_MNGR2PROC  12'hFC0
`define PIPE_CSR_PROC2MNGR  12'h7C0

// Canonical NOP, addi x0, x0, 0
`define PIPE_INST_NOP  32'h0000_0013

`endif

// ==== rv_isa_pkg.sv ====
//------------------------------
// RV32 instruction word views used by decode
// Only the opcodes of the supported subset are named
//------------------------------
`include "pipe_defs.svh"

package rv_isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_load   = 7'b0000011,
    opc_branch = 7'b1100011,
    opc_system = 7'b1110011
  } opcode_e;

  // Register-register view
  typedef struct packed {
    logic [6:0]               funct7;
    logic [`PIPE_RADDR_W-1:0] rs2;
    logic [`PIPE_RADDR_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`PIPE_RADDR_W-1:0] rd;
    opcode_e                  opcode;
  } inst_r_t;

  // CSR view, upper twelve bits hold the CSR number
  typedef struct packed {
    logic [`PIPE_CSR_W-1:0]   csr;
    logic [`PIPE_RADDR_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`PIPE_RADDR_W-1:0] rd;
    opcode_e                  opcode;
  } inst_csr_t;

  // Same word, two readings of bits 31:20
  typedef union packed {
    inst_r_t   r;
    inst_csr_t c;
  } inst_u;

endpackage

// ==== pipe_ctrl_pkg.sv ====
//------------------------------
// Datapath select encodings and per-stage control bundles
//------------------------------
`include "pipe_defs.svh"

package pipe_ctrl_pkg;

  // ALU function, values match the datapath ALU
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sra  = 4'd7,
    alu_srl  = 4'd8,
    alu_sll  = 4'd9,
    alu_cp0  = 4'd11,
    alu_cp1  = 4'd12
  } alu_fn_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;
  typedef enum logic {op1_rf, op1_pc} op1_sel_e;
  typedef enum logic [1:0] {op2_rf, op2_imm, op2_csr} op2_sel_e;
  typedef enum logic [1:0] {pc_plus4, pc_branch} pc_sel_e;

  // Pending register write of one stage, seen by the hazard check
  typedef struct packed {
    logic                     val;
    logic                     wen_pending;
    logic [`PIPE_RADDR_W-1:0] waddr;
  } dest_t;

  // D to X bundle
  typedef struct packed {
    logic                     val;
    alu_fn_e                  alu_fn;
    logic                     is_bne;
    logic                     is_load;
    logic                     wb_from_mem;
    logic                     wen_pending;
    logic [`PIPE_RADDR_W-1:0] waddr;
    logic                     proc2mngr;
  } x_ctrl_t;

  // X to M bundle
  typedef struct packed {
    logic                     val;
    logic                     is_load;
    logic                     wb_from_mem;
    logic                     wen_pending;
    logic [`PIPE_RADDR_W-1:0] waddr;
    logic                     proc2mngr;
  } m_ctrl_t;

endpackage

// ==== fetch_decode_ctrl.sv ====
`timescale 1ns/1ps
//------------------------------
// F and D control, no bypassing: RAW hazards stall D until the
// producer leaves W. inst_d_i must hold steady while D stalls
//------------------------------
`include "pipe_defs.svh"

module fetch_decode_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      imemresp_val_i,
  input  logic                      mngr2proc_val_i,
  input  rv_isa_pkg::inst_u         inst_d_i,
  input  logic                      squash_x_i,
  input  logic                      ostall_x_i,
  input  logic                      ostall_m_i,
  input  logic                      ostall_w_i,
  input  pipe_ctrl_pkg::dest_t      dest_x_i,
  input  pipe_ctrl_pkg::dest_t      dest_m_i,
  input  pipe_ctrl_pkg::dest_t      dest_w_i,
  output logic                      reg_en_f_o,
  output logic                      reg_en_d_o,
  output logic                      imemreq_val_o,
  output logic                      imemresp_rdy_o,
  output logic                      imemresp_drop_o,
  output logic                      mngr2proc_rdy_o,
  output pipe_ctrl_pkg::op1_sel_e   op1_sel_d_o,
  output pipe_ctrl_pkg::op2_sel_e   op2_sel_d_o,
  output pipe_ctrl_pkg::imm_type_e  imm_type_d_o,
  output pipe_ctrl_pkg::x_ctrl_t    x_ctrl_o
);

  logic val_f;
  logic val_d;
  logic ostall_f;
  logic stall_f;
  logic squash_f;
  logic ostall_d;
  logic stall_d;
  logic squash_d;
  logic ostall_younger;
  logic rs1_en_d;
  logic rs2_en_d;
  logic wen_d;
  logic is_bne_d;
  logic is_load_d;
  logic mngr_rd_d;
  logic proc2mngr_d;
  logic ostall_hazard_d;
  pipe_ctrl_pkg::alu_fn_e alu_fn_d;

  // funct3 to ALU op, alt is funct7 bit 5 (sub and sra)
  function automatic pipe_ctrl_pkg::alu_fn_e alu_from_f3(input logic [2:0] f3,
                                                         input logic alt,
                                                         input logic reg_op);
    case (f3)
      3'b000: begin
        if (reg_op && alt) alu_from_f3 = pipe_ctrl_pkg::alu_sub;
        else               alu_from_f3 = pipe_ctrl_pkg::alu_add;
      end
      3'b001: alu_from_f3 = pipe_ctrl_pkg::alu_sll;
      3'b010: alu_from_f3 = pipe_ctrl_pkg::alu_slt;
      3'b011: alu_from_f3 = pipe_ctrl_pkg::alu_sltu;
      3'b100: alu_from_f3 = pipe_ctrl_pkg::alu_xor;
      3'b101: begin
        if (alt) alu_from_f3 = pipe_ctrl_pkg::alu_sra;
        else     alu_from_f3 = pipe_ctrl_pkg::alu_srl;
      end
      3'b110:  alu_from_f3 = pipe_ctrl_pkg::alu_or;
      default: alu_from_f3 = pipe_ctrl_pkg::alu_and;
    endcase
  endfunction

  // Source read against one later stage's pending write, x0 never hazards
  function automatic logic raw_hit(input logic en, input logic [`PIPE_RADDR_W-1:0] rs,
                                   input pipe_ctrl_pkg::dest_t dest);
    raw_hit = en && dest.val && dest.wen_pending && (dest.waddr == rs) && (rs != '0);
  endfunction

  assign ostall_younger = ostall_x_i || ostall_m_i || ostall_w_i;

  //------------------------------
  // F stage
  //------------------------------
  assign ostall_f   = val_f && !imemresp_val_i;
  assign stall_f    = val_f && (ostall_f || ostall_d || ostall_younger);
  assign squash_f   = val_f && squash_x_i;
  assign reg_en_f_o = !stall_f || squash_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (reg_en_f_o) begin
      val_f <= 1'b1;
    end
  end

  // Request goes out ahead of F; a squashed response is dropped
  assign imemreq_val_o   = reg_en_f_o && !reset;
  assign imemresp_rdy_o  = reg_en_f_o;
  assign imemresp_drop_o = squash_f;

  //------------------------------
  // D stage
  //------------------------------
  assign reg_en_d_o = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d_o) begin
      val_d <= val_f && !stall_f && !squash_f;
    end
  end

  // Control table, defaults describe a no-write bubble
  always_comb begin
    op1_sel_d_o  = pipe_ctrl_pkg::op1_rf;
    op2_sel_d_o  = pipe_ctrl_pkg::op2_rf;
    imm_type_d_o = pipe_ctrl_pkg::imm_i;
    alu_fn_d     = pipe_ctrl_pkg::alu_add;
    rs1_en_d     = 1'b0;
    rs2_en_d     = 1'b0;
    wen_d        = 1'b0;
    is_bne_d     = 1'b0;
    is_load_d    = 1'b0;
    mngr_rd_d    = 1'b0;
    proc2mngr_d  = 1'b0;
    case (inst_d_i.r.opcode)
      rv_isa_pkg::opc_op: begin
        // Any funct7 other than base or alt (e.g. MUL) stays a bubble
        if (inst_d_i.r.funct7 == 7'h00 || inst_d_i.r.funct7 == 7'h20) begin
          rs1_en_d = 1'b1;
          rs2_en_d = 1'b1;
          wen_d    = 1'b1;
          alu_fn_d = alu_from_f3(inst_d_i.r.funct3, inst_d_i.r.funct7[5], 1'b1);
        end
      end
      rv_isa_pkg::opc_op_imm: begin
        op2_sel_d_o = pipe_ctrl_pkg::op2_imm;
        rs1_en_d    = 1'b1;
        // NOP is an addi to x0 and must not show as a write
        wen_d       = (inst_d_i != `PIPE_INST_NOP);
        alu_fn_d    = alu_from_f3(inst_d_i.r.funct3, inst_d_i.r.funct7[5], 1'b0);
      end
      rv_isa_pkg::opc_lui: begin
        imm_type_d_o = pipe_ctrl_pkg::imm_u;
        op2_sel_d_o  = pipe_ctrl_pkg::op2_imm;
        alu_fn_d     = pipe_ctrl_pkg::alu_cp1;
        wen_d        = 1'b1;
      end
      rv_isa_pkg::opc_auipc: begin
        imm_type_d_o = pipe_ctrl_pkg::imm_u;
        op1_sel_d_o  = pipe_ctrl_pkg::op1_pc;
        op2_sel_d_o  = pipe_ctrl_pkg::op2_imm;
        wen_d        = 1'b1;
      end
      rv_isa_pkg::opc_load: begin
        if (inst_d_i.r.funct3 == 3'b010) begin
          op2_sel_d_o = pipe_ctrl_pkg::op2_imm;
          rs1_en_d    = 1'b1;
          wen_d       = 1'b1;
          is_load_d   = 1'b1;
        end
      end
      rv_isa_pkg::opc_branch: begin
        if (inst_d_i.r.funct3 == 3'b001) begin
          imm_type_d_o = pipe_ctrl_pkg::imm_b;
          rs1_en_d     = 1'b1;
          rs2_en_d     = 1'b1;
          is_bne_d     = 1'b1;
        end
      end
      rv_isa_pkg::opc_system: begin
        // csrr reads through the op2 mux, csrw passes rs1 out
        if (inst_d_i.c.funct3 == 3'b010) begin
          op2_sel_d_o = pipe_ctrl_pkg::op2_csr;
          alu_fn_d    = pipe_ctrl_pkg::alu_cp1;
          wen_d       = 1'b1;
          mngr_rd_d   = (inst_d_i.c.csr == `PIPE_CSR_MNGR2PROC);
        end else if (inst_d_i.c.funct3 == 3'b001) begin
          rs1_en_d    = 1'b1;
          alu_fn_d    = pipe_ctrl_pkg::alu_cp0;
          proc2mngr_d = (inst_d_i.c.csr == `PIPE_CSR_PROC2MNGR);
        end
      end
      default: ;
    endcase
  end

  // RAW check against X, M and W
  assign ostall_hazard_d = raw_hit(rs1_en_d, inst_d_i.r.rs1, dest_x_i) ||
                           raw_hit(rs1_en_d, inst_d_i.r.rs1, dest_m_i) ||
                           raw_hit(rs1_en_d, inst_d_i.r.rs1, dest_w_i) ||
                           raw_hit(rs2_en_d, inst_d_i.r.rs2, dest_x_i) ||
                           raw_hit(rs2_en_d, inst_d_i.r.rs2, dest_m_i) ||
                           raw_hit(rs2_en_d, inst_d_i.r.rs2, dest_w_i);

  assign ostall_d = val_d && (ostall_hazard_d || (mngr_rd_d && !mngr2proc_val_i));
  assign stall_d  = val_d && (ostall_d || ostall_younger);
  assign squash_d = val_d && squash_x_i;

  // Wrong-path csrr must not consume a manager message
  assign mngr2proc_rdy_o = val_d && !stall_d && !squash_d && mngr_rd_d;

  always_comb begin
    x_ctrl_o.val         = val_d && !stall_d && !squash_d;
    x_ctrl_o.alu_fn      = alu_fn_d;
    x_ctrl_o.is_bne      = is_bne_d;
    x_ctrl_o.is_load     = is_load_d;
    x_ctrl_o.wb_from_mem = is_load_d;
    x_ctrl_o.wen_pending = wen_d;
    x_ctrl_o.waddr       = inst_d_i.r.rd;
    x_ctrl_o.proc2mngr   = proc2mngr_d;
  end

endmodule

// ==== execute_ctrl.sv ====
`timescale 1ns/1ps
//------------------------------
// X control, branch resolves here and squashes F and D
//------------------------------

module execute_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  pipe_ctrl_pkg::x_ctrl_t  x_ctrl_i,
  input  logic                    br_cond_eq_x_i,
  input  logic                    dmemreq_rdy_i,
  input  logic                    ostall_m_i,
  input  logic                    ostall_w_i,
  output logic                    reg_en_x_o,
  output pipe_ctrl_pkg::alu_fn_e  alu_fn_x_o,
  output pipe_ctrl_pkg::pc_sel_e  pc_sel_f_o,
  output logic                    dmemreq_val_o,
  output logic                    squash_x_o,
  output logic                    ostall_x_o,
  output pipe_ctrl_pkg::dest_t    dest_x_o,
  output pipe_ctrl_pkg::m_ctrl_t  m_ctrl_o
);

  pipe_ctrl_pkg::x_ctrl_t x_q;
  logic stall_x;
  logic redirect_x;

  assign reg_en_x_o = !stall_x;

  // Only the valid bit needs a reset
  always_ff @(posedge clk) begin
    if (reset) begin
      x_q.val <= 1'b0;
    end else if (reg_en_x_o) begin
      x_q <= x_ctrl_i;
    end
  end

  assign alu_fn_x_o = x_q.alu_fn;

  // Taken bne picks the branch target this cycle
  assign redirect_x = x_q.val && x_q.is_bne && !br_cond_eq_x_i;
  assign pc_sel_f_o = redirect_x ? pipe_ctrl_pkg::pc_branch : pipe_ctrl_pkg::pc_plus4;

  assign ostall_x_o = x_q.val && x_q.is_load && !dmemreq_rdy_i;
  assign stall_x    = x_q.val && (ostall_x_o || ostall_m_i || ostall_w_i);

  // A stalled X would squash twice, so hold it back until X moves
  assign squash_x_o    = redirect_x && !stall_x;
  assign dmemreq_val_o = x_q.val && !stall_x && x_q.is_load;

  assign dest_x_o = '{val: x_q.val, wen_pending: x_q.wen_pending, waddr: x_q.waddr};

  always_comb begin
    m_ctrl_o.val         = x_q.val && !stall_x;
    m_ctrl_o.is_load     = x_q.is_load;
    m_ctrl_o.wb_from_mem = x_q.wb_from_mem;
    m_ctrl_o.wen_pending = x_q.wen_pending;
    m_ctrl_o.waddr       = x_q.waddr;
    m_ctrl_o.proc2mngr   = x_q.proc2mngr;
  end

endmodule

// ==== result_ctrl.sv ====
`timescale 1ns/1ps
//------------------------------
// M and W control; M waits on the load response, W on the manager
//------------------------------
`include "pipe_defs.svh"

module result_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  pipe_ctrl_pkg::m_ctrl_t    m_ctrl_i,
  input  logic                      dmemresp_val_i,
  input  logic                      proc2mngr_rdy_i,
  output logic                      reg_en_m_o,
  output logic                      reg_en_w_o,
  output logic                      wb_result_sel_m_o,
  output logic                      dmemresp_rdy_o,
  output logic                      ostall_m_o,
  output logic                      ostall_w_o,
  output pipe_ctrl_pkg::dest_t      dest_m_o,
  output pipe_ctrl_pkg::dest_t      dest_w_o,
  output logic [`PIPE_RADDR_W-1:0]  rf_waddr_w_o,
  output logic                      rf_wen_w_o,
  output logic                      proc2mngr_val_o,
  output logic                      commit_inst_o
);

  pipe_ctrl_pkg::m_ctrl_t m_q;
  logic stall_m;
  logic stall_w;
  logic val_w;
  logic wen_pending_w;
  logic proc2mngr_w;

  //------------------------------
  // M stage
  //------------------------------
  assign reg_en_m_o = !stall_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      m_q.val <= 1'b0;
    end else if (reg_en_m_o) begin
      m_q <= m_ctrl_i;
    end
  end

  assign ostall_m_o        = m_q.val && m_q.is_load && !dmemresp_val_i;
  assign stall_m           = m_q.val && (ostall_m_o || ostall_w_o);
  assign dmemresp_rdy_o    = m_q.val && !stall_m && m_q.is_load;
  assign wb_result_sel_m_o = m_q.wb_from_mem;
  assign dest_m_o = '{val: m_q.val, wen_pending: m_q.wen_pending, waddr: m_q.waddr};

  //------------------------------
  // W stage
  //------------------------------
  assign reg_en_w_o = !stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (reg_en_w_o) begin
      val_w         <= m_q.val && !stall_m;
      wen_pending_w <= m_q.wen_pending;
      rf_waddr_w_o  <= m_q.waddr;
      proc2mngr_w   <= m_q.proc2mngr;
    end
  end

  // Only a csrw to the manager can hold W
  assign ostall_w_o = val_w && proc2mngr_w && !proc2mngr_rdy_i;
  assign stall_w    = val_w && ostall_w_o;
  assign dest_w_o   = '{val: val_w, wen_pending: wen_pending_w, waddr: rf_waddr_w_o};

  assign rf_wen_w_o      = val_w && !stall_w && wen_pending_w;
  assign proc2mngr_val_o = val_w && !stall_w && proc2mngr_w;
  assign commit_inst_o   = val_w && !stall_w;

endmodule

// ==== proc_ctrl_top.sv ====
`timescale 1ns/1ps
//------------------------------
// Control unit of the five-stage stalling pipeline
// All outside ports are plain val/rdy, transfer on both high
//------------------------------
`include "pipe_defs.svh"

module proc_ctrl_top (
  input  logic                      clk,
  input  logic                      reset,
  // Instruction memory
  output logic                      imemreq_val_o,
  input  logic                      imemresp_val_i,
  output logic                      imemresp_rdy_o,
  output logic                      imemresp_drop_o,
  // Data memory
  output logic                      dmemreq_val_o,
  input  logic                      dmemreq_rdy_i,
  input  logic                      dmemresp_val_i,
  output logic                      dmemresp_rdy_o,
  // Manager
  input  logic                      mngr2proc_val_i,
  output logic                      mngr2proc_rdy_o,
  output logic                      proc2mngr_val_o,
  input  logic                      proc2mngr_rdy_i,
  // Datapath controls
  output logic                      reg_en_f_o,
  output pipe_ctrl_pkg::pc_sel_e    pc_sel_f_o,
  output logic                      reg_en_d_o,
  output pipe_ctrl_pkg::op1_sel_e   op1_sel_d_o,
  output pipe_ctrl_pkg::op2_sel_e   op2_sel_d_o,
  output pipe_ctrl_pkg::imm_type_e  imm_type_d_o,
  output logic                      reg_en_x_o,
  output pipe_ctrl_pkg::alu_fn_e    alu_fn_x_o,
  output logic                      reg_en_m_o,
  output logic                      wb_result_sel_m_o,
  output logic                      reg_en_w_o,
  output logic [`PIPE_RADDR_W-1:0]  rf_waddr_w_o,
  output logic                      rf_wen_w_o,
  // Datapath status
  input  rv_isa_pkg::inst_u         inst_d_i,
  input  logic                      br_cond_eq_x_i,
  output logic                      commit_inst_o
);

  // Stage bundles
  pipe_ctrl_pkg::x_ctrl_t x_ctrl;
  pipe_ctrl_pkg::m_ctrl_t m_ctrl;
  pipe_ctrl_pkg::dest_t   dest_x;
  pipe_ctrl_pkg::dest_t   dest_m;
  pipe_ctrl_pkg::dest_t   dest_w;

  // Stall network, each older stage ORs these in
  logic squash_x;
  logic ostall_x;
  logic ostall_m;
  logic ostall_w;

  fetch_decode_ctrl u_fd (
    .clk             (clk),
    .reset           (reset),
    .imemresp_val_i  (imemresp_val_i),
    .mngr2proc_val_i (mngr2proc_val_i),
    .inst_d_i        (inst_d_i),
    .squash_x_i      (squash_x),
    .ostall_x_i      (ostall_x),
    .ostall_m_i      (ostall_m),
    .ostall_w_i      (ostall_w),
    .dest_x_i        (dest_x),
    .dest_m_i        (dest_m),
    .dest_w_i        (dest_w),
    .reg_en_f_o      (reg_en_f_o),
    .reg_en_d_o      (reg_en_d_o),
    .imemreq_val_o   (imemreq_val_o),
    .imemresp_rdy_o  (imemresp_rdy_o),
    .imemresp_drop_o (imemresp_drop_o),
    .mngr2proc_rdy_o (mngr2proc_rdy_o),
    .op1_sel_d_o     (op1_sel_d_o),
    .op2_sel_d_o     (op2_sel_d_o),
    .imm_type_d_o    (imm_type_d_o),
    .x_ctrl_o        (x_ctrl)
  );

  execute_ctrl u_x (
    .clk            (clk),
    .reset          (reset),
    .x_ctrl_i       (x_ctrl),
    .br_cond_eq_x_i (br_cond_eq_x_i),
    .dmemreq_rdy_i  (dmemreq_rdy_i),
    .ostall_m_i     (ostall_m),
    .ostall_w_i     (ostall_w),
    .reg_en_x_o     (reg_en_x_o),
    .alu_fn_x_o     (alu_fn_x_o),
    .pc_sel_f_o     (pc_sel_f_o),
    .dmemreq_val_o  (dmemreq_val_o),
    .squash_x_o     (squash_x),
    .ostall_x_o     (ostall_x),
    .dest_x_o       (dest_x),
    .m_ctrl_o       (m_ctrl)
  );

  result_ctrl u_mw (
    .clk               (clk),
    .reset             (reset),
    .m_ctrl_i          (m_ctrl),
    .dmemresp_val_i    (dmemresp_val_i),
    .proc2mngr_rdy_i   (proc2mngr_rdy_i),
    .reg_en_m_o        (reg_en_m_o),
    .reg_en_w_o        (reg_en_w_o),
    .wb_result_sel_m_o (wb_result_sel_m_o),
    .dmemresp_rdy_o    (dmemresp_rdy_o),
    .ostall_m_o        (ostall_m),
    .ostall_w_o        (ostall_w),
    .dest_m_o          (dest_m),
    .dest_w_o          (dest_w),
    .rf_waddr_w_o      (rf_waddr_w_o),
    .rf_wen_w_o        (rf_wen_w_o),
    .proc2mngr_val_o   (proc2mngr_val_o),
    .commit_inst_o     (commit_inst_o)
  );

endmodule

// ==== proc_ctrl_chk.sv ====
`timescale 1ns/1ps
//------------------------------
// Handshake and reset assertions, bound into proc_ctrl_top
//------------------------------

module proc_ctrl_chk (
  input logic clk,
  input logic reset,
  input logic imemresp_rdy_i,
  input logic imemresp_drop_i,
  input logic dmemreq_val_i,
  input logic dmemresp_val_i,
  input logic dmemresp_rdy_i,
  input logic mngr2proc_rdy_i,
  input logic proc2mngr_val_i
);

  logic load_in_m;
  int   assert_fails = 0;

  // A load enters M with its request and leaves with its response
  always_ff @(posedge clk) begin
    if (reset) begin
      load_in_m <= 1'b0;
    end else if (dmemreq_val_i) begin
      load_in_m <= 1'b1;
    end else if (dmemresp_rdy_i && dmemresp_val_i) begin
      load_in_m <= 1'b0;
    end
  end

  // Nothing leaves the core in the first cycle after reset
  quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !dmemreq_val_i && !mngr2proc_rdy_i && !proc2mngr_val_i)
    else begin
      $error("request strobe in the first cycle after reset");
      assert_fails++;
    end

  resp_rdy_needs_load: assert property (@(posedge clk) disable iff (reset)
    dmemresp_rdy_i |-> load_in_m)
    else begin
      $error("dmemresp_rdy without a load in M");
      assert_fails++;
    end

  // Drop marks the response being taken
  drop_with_rdy: assert property (@(posedge clk) disable iff (reset)
    imemresp_drop_i |-> imemresp_rdy_i)
    else begin
      $error("imemresp_drop without imemresp_rdy");
      assert_fails++;
    end

endmodule

bind proc_ctrl_top proc_ctrl_chk chk (
  .clk             (clk),
  .reset           (reset),
  .imemresp_rdy_i  (imemresp_rdy_o),
  .imemresp_drop_i (imemresp_drop_o),
  .dmemreq_val_i   (dmemreq_val_o),
  .dmemresp_val_i  (dmemresp_val_i),
  .dmemresp_rdy_i  (dmemresp_rdy_o),
  .mngr2proc_rdy_i (mngr2proc_rdy_o),
  .proc2mngr_val_i (proc2mngr_val_o)
);

// ==== proc_ctrl_tb.sv ====
`timescale 1ns/1ps
//------------------------------
// Testbench for proc_ctrl_top, program rows come from proc_ctrl_testdata.txt
// Imem answers every request at once; wrong-path rows must follow a taken BNE
//------------------------------
`include "pipe_defs.svh"

module proc_ctrl_tb;

  localparam int MAX_ROWS    = 64;
  localparam int HALF_PERIOD = 50;
  localparam int ROW_CYCLES  = 40;

  logic clk;
  logic reset;
  logic imemreq_val_o;
  logic imemresp_val_i;
  logic imemresp_rdy_o;
  logic imemresp_drop_o;
  logic dmemreq_val_o;
  logic dmemreq_rdy_i;
  logic dmemresp_val_i;
  logic dmemresp_rdy_o;
  logic mngr2proc_val_i;
  logic mngr2proc_rdy_o;
  logic proc2mngr_val_o;
  logic proc2mngr_rdy_i;
  logic reg_en_f_o;
  logic reg_en_d_o;
  logic reg_en_x_o;
  logic reg_en_m_o;
  logic reg_en_w_o;
  logic wb_result_sel_m_o;
  logic rf_wen_w_o;
  logic br_cond_eq_x_i;
  logic commit_inst_o;
  logic [`PIPE_RADDR_W-1:0] rf_waddr_w_o;
  pipe_ctrl_pkg::pc_sel_e    pc_sel_f_o;
  pipe_ctrl_pkg::op1_sel_e   op1_sel_d_o;
  pipe_ctrl_pkg::op2_sel_e   op2_sel_d_o;
  pipe_ctrl_pkg::imm_type_e  imm_type_d_o;
  pipe_ctrl_pkg::alu_fn_e    alu_fn_x_o;
  rv_isa_pkg::inst_u         inst_d_i;

  // Four words per row: instruction, taken, wrong path, expected rd
  logic [31:0] tdata [0:4*MAX_ROWS-1];
  int n_rows = 0;
  int right_rows [$];
  integer seed;

  // Shadow of F, D and X as row indices
  int pc;
  int f_row;
  int d_row;
  int x_row;
  bit f_val;
  bit d_val;
  bit x_val;

  // Transfer and commit counters
  int commits;
  int dmem_reqs;
  int dmem_resps;
  int m2p_xfers;
  int p2m_xfers;
  int lw_commits;
  int csrr_commits;
  int csrw_commits;

  proc_ctrl_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  function automatic logic [31:0] row_word(input int row);
    if (row < n_rows) row_word = tdata[4*row];
    else              row_word = `PIPE_INST_NOP;
  endfunction

  // First right-path row after a taken BNE
  function automatic int branch_target(input int row);
    int t;
    t = row + 1;
    while (t < n_rows && tdata[4*t+2][0]) t++;
    return t;
  endfunction

  function automatic bit is_load_word(input logic [31:0] w);
    return w[6:0] == 7'b0000011 && w[14:12] == 3'b010;
  endfunction

  function automatic bit is_mngr_read(input logic [31:0] w);
    return w[6:0] == 7'b1110011 && w[14:12] == 3'b010 && w[31:20] == `PIPE_CSR_MNGR2PROC;
  endfunction

  function automatic bit is_mngr_write(input logic [31:0] w);
    return w[6:0] == 7'b1110011 && w[14:12] == 3'b001 && w[31:20] == `PIPE_CSR_PROC2MNGR;
  endfunction

  // ALU function from the ISA encoding, bit 30 picks sub and sra
  function automatic logic [3:0] expected_alu(input logic [31:0] w);
    logic [2:0] f3;
    f3 = w[14:12];
    case (w[6:0])
      7'b0110111: return 4'd12;
      7'b1110011: return (f3 == 3'b010) ? 4'd12 : 4'd11;
      7'b0110011, 7'b0010011: begin
        case (f3)
          3'd0:    return (w[6:0] == 7'b0110011 && w[30]) ? 4'd1 : 4'd0;
          3'd1:    return 4'd9;
          3'd2:    return 4'd5;
          3'd3:    return 4'd6;
          3'd4:    return 4'd4;
          3'd5:    return w[30] ? 4'd7 : 4'd8;
          3'd6:    return 4'd3;
          default: return 4'd2;
        endcase
      end
      default: return 4'd0;
    endcase
  endfunction

  // Operand and immediate selects as {op1, op2, imm}
  function automatic logic [5:0] expected_d_sel(input logic [31:0] w);
    case (w[6:0])
      7'b0010011, 7'b0000011: return {1'b0, 2'd1, 3'd0};
      7'b0110111:             return {1'b0, 2'd1, 3'd3};
      7'b0010111:             return {1'b1, 2'd1, 3'd3};
      7'b1100011:             return {1'b0, 2'd0, 3'd2};
      7'b1110011:             return {1'b0, (w[14:12] == 3'b010) ? 2'd2 : 2'd0, 3'd0};
      default:                return {1'b0, 2'd0, 3'd0};
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_idle_outputs(input string phase);
    compare_value({phase, " dmemreq_val"}, 0, dmemreq_val_o);
    compare_value({phase, " proc2mngr_val"}, 0, proc2mngr_val_o);
    compare_value({phase, " mngr2proc_rdy"}, 0, mngr2proc_rdy_o);
    compare_value({phase, " rf_wen"}, 0, rf_wen_w_o);
    compare_value({phase, " commit"}, 0, commit_inst_o);
  endtask

  // Called at a rising edge, sees the values of the cycle that just ended
  task automatic sample_cycle();
    bit squash;
    int req_row;
    int row;
    squash = (pc_sel_f_o == pipe_ctrl_pkg::pc_branch) && reg_en_x_o;
    // Redirect target comes from the BNE still in X
    req_row = (pc_sel_f_o == pipe_ctrl_pkg::pc_branch) ? branch_target(x_row) : pc;
    if (d_val) begin
      compare_value($sformatf("row %0d d selects", d_row), expected_d_sel(row_word(d_row)),
                    {op1_sel_d_o, op2_sel_d_o, imm_type_d_o});
    end
    if (x_val) begin
      compare_value($sformatf("row %0d alu_fn", x_row), expected_alu(row_word(x_row)),
                    alu_fn_x_o);
    end
    if (dmemreq_val_o && dmemreq_rdy_i) dmem_reqs++;
    if (dmemresp_rdy_o && dmemresp_val_i) begin
      dmem_resps++;
      compare_value("load wb_result_sel", 1, wb_result_sel_m_o);
      compare_value("load reg_en_m", 1, reg_en_m_o);
    end
    if (mngr2proc_rdy_o && mngr2proc_val_i) m2p_xfers++;
    if (proc2mngr_val_o && proc2mngr_rdy_i) p2m_xfers++;
    if (commit_inst_o) begin
      if (commits >= right_rows.size()) begin
        $display("A row committed after the whole program had already committed");
        $display("Finished with errors");
        $fatal(1, "extra commit");
      end
      row = right_rows[commits];
      compare_value($sformatf("row %0d reg_en_w", row), 1, reg_en_w_o);
      compare_value($sformatf("row %0d rf_wen", row), tdata[4*row+3] != 0, rf_wen_w_o);
      if (rf_wen_w_o) begin
        compare_value($sformatf("row %0d rf_waddr", row), tdata[4*row+3], rf_waddr_w_o);
      end
      if (is_load_word(row_word(row))) lw_commits++;
      if (is_mngr_read(row_word(row))) csrr_commits++;
      if (is_mngr_write(row_word(row))) csrw_commits++;
      // Transfers of this row are already done when it commits
      compare_value($sformatf("row %0d dmem req", row), 1, dmem_reqs >= lw_commits);
      compare_value($sformatf("row %0d mngr2proc", row), 1, m2p_xfers >= csrr_commits);
      compare_value($sformatf("row %0d proc2mngr", row), csrw_commits, p2m_xfers);
      commits++;
    end
    // Oldest first so each stage takes the old value of the one before
    if (reg_en_x_o) begin
      x_val = d_val && reg_en_d_o && !squash;
      x_row = d_row;
    end
    if (reg_en_d_o) begin
      d_val = f_val && reg_en_f_o && !squash;
      d_row = f_row;
    end
    if (imemreq_val_o) begin
      f_row = req_row;
      f_val = 1'b1;
      pc    = req_row + 1;
    end
  endtask

  task automatic drive_inputs();
    // Past the last row imem goes silent and F starves
    imemresp_val_i  = f_val && (f_row < n_rows);
    inst_d_i        = d_val ? row_word(d_row) : `PIPE_INST_NOP;
    br_cond_eq_x_i  = !(x_val && tdata[4*x_row+1][0]);
    dmemreq_rdy_i   = ($random(seed) & 3) != 0;
    dmemresp_val_i  = ($random(seed) & 3) != 0;
    mngr2proc_val_i = ($random(seed) & 3) != 0;
    proc2mngr_rdy_i = ($random(seed) & 3) != 0;
  endtask

  task automatic run_cycle();
    @(posedge clk);
    sample_cycle();
    #1;
    drive_inputs();
  endtask

  initial begin
    int rows;
    seed = 97;
    reset = 1'b1;
    imemresp_val_i  = 1'b0;
    dmemreq_rdy_i   = 1'b0;
    dmemresp_val_i  = 1'b0;
    mngr2proc_val_i = 1'b0;
    proc2mngr_rdy_i = 1'b0;
    br_cond_eq_x_i  = 1'b1;
    inst_d_i        = `PIPE_INST_NOP;
    for (int i = 0; i < 4*MAX_ROWS; i++) tdata[i] = 'x;
    $readmemh("proc_ctrl_testdata.txt", tdata);
    rows = 0;
    while (rows < MAX_ROWS && !$isunknown(tdata[4*rows])) rows++;
    if (rows == 0) begin
      $display("The data file proc_ctrl_testdata.txt holds no rows");
      $display("Finished with errors");
      $fatal(1, "no stimulus");
    end
    for (int r = 0; r < rows; r++) begin
      if (!tdata[4*r+2][0]) right_rows.push_back(r);
    end
    n_rows = rows;

    // First edge clears the valid bits, second one sees them idle
    repeat (2) @(posedge clk);
    check_idle_outputs("reset");
    #1;
    reset = 1'b0;
    drive_inputs();
    @(posedge clk);
    check_idle_outputs("first cycle after reset");
    sample_cycle();
    #1;
    drive_inputs();
    while (commits < right_rows.size()) run_cycle();
    // Drain, a late wrong-path commit would show up here
    repeat (10) run_cycle();

    compare_value("committed rows", right_rows.size(), commits);
    compare_value("dmem requests", lw_commits, dmem_reqs);
    compare_value("dmem responses", lw_commits, dmem_resps);
    compare_value("mngr2proc transfers", csrr_commits, m2p_xfers);
    compare_value("proc2mngr transfers", csrw_commits, p2m_xfers);
    if (dut.chk.assert_fails != 0) begin
      $display("Bound assertions failed %0d times", dut.chk.assert_fails);
      $display("Finished with errors");
      $fatal(1, "assertion failures");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // Budget of ROW_CYCLES per data row
  initial begin
    wait (n_rows > 0);
    repeat (n_rows * ROW_CYCLES + 4) @(posedge clk);
    $display("Watchdog expired, the pipeline stopped committing (%0d of %0d rows)",
             commits, right_rows.size());
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

endmodule

// ==== proc_ctrl_testdata.txt ====
// Columns: instruction word, BNE taken (1), wrong path (1), expected rd (00 = no write)
// Wrong-path rows sit right after a taken BNE; the first row after them is the target
000100B7 0 0 01  // lui   x1, 0x10
00508113 0 0 02  // addi  x2, x1, 5
002081B3 0 0 03  // add   x3, x1, x2
40118233 0 0 04  // sub   x4, x3, x1
00022283 0 0 05  // lw    x5, 0(x4)
0022F333 0 0 06  // and   x6, x5, x2
FC0023F3 0 0 07  // csrr  x7, mngr2proc
0063C433 0 0 08  // xor   x8, x7, x6
00041663 1 0 00  // bne   x8, x0, +12
00100493 0 1 09  // addi  x9, x0, 1
7C049073 0 1 00  // csrw  proc2mngr, x9
00342533 0 0 0A  // slt   x10, x8, x3
008535B3 0 0 0B  // sltu  x11, x10, x8
4025D613 0 0 0C  // srai  x12, x11, 2
00109463 0 0 00  // bne   x1, x1, +8
00000013 0 0 00  // nop
7C061073 0 0 00  // csrw  proc2mngr, x12
00001697 0 0 0D  // auipc x13, 1
00069663 1 0 00  // bne   x13, x0, +12
00082883 0 1 11  // lw    x17, 0(x16)
FC002973 0 1 12  // csrr  x18, mngr2proc
0046A983 0 0 13  // lw    x19, 4(x13)
7C099073 0 0 00  // csrw  proc2mngr, x19

// ==== verilog.f ====
+incdir+.
rv_isa_pkg.sv
pipe_ctrl_pkg.sv
fetch_decode_ctrl.sv
execute_ctrl.sv
result_ctrl.sv
proc_ctrl_top.sv
proc_ctrl_chk.sv
proc_ctrl_tb.sv
